// File: build.f
hw/cache_cfg_pkg.sv
hw/cache_bus_pkg.sv
hw/way_lfsr.sv
hw/tag_store.sv
hw/data_store.sv
hw/cache_ctrl.sv
hw/cache_top.sv
dv/tb_clock_gen.sv
dv/cache_assertions.sv
dv/cache_tb.sv

// File: Bender.yml
package:
  name: two_way_dcache

sources:
  - hw/cache_cfg_pkg.sv
  - hw/cache_bus_pkg.sv
  - hw/way_lfsr.sv
  - hw/tag_store.sv
  - hw/data_store.sv
  - hw/cache_ctrl.sv
  - hw/cache_top.sv
  - target: simulation
    files:
      - dv/tb_clock_gen.sv
      - dv/cache_assertions.sv
      - dv/cache_tb.sv

// File: dv/cache_tb.sv
module cache_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int n_requests  = 400;
    localparam int cycle_limit = n_requests * 30 + 100;
    localparam int n_blocks    = 8192;
    localparam cache_cfg_pkg::block_addr_t window_base = 13'h0a40;  // 64 blocks with 4 per set

    logic clk, rst_aL;
    logic req_valid, req_ready, resp_valid;
    logic mem_req_valid, mem_req_ready, mem_resp_valid;
    cache_bus_pkg::req_type_t   req_type, mem_req_type;
    cache_bus_pkg::req_width_t  req_width;
    cache_cfg_pkg::addr_t       req_addr;
    cache_cfg_pkg::word_t       req_wr_data;
    cache_cfg_pkg::block_addr_t mem_req_block_addr;
    cache_cfg_pkg::block_t      resp_data, mem_req_block_data, mem_resp_block_data;

    cache_cfg_pkg::block_t mem_blocks [n_blocks];  // memory controller model
    logic [7:0]  ref_mem [1 << cache_cfg_pkg::addr_w];  // reference byte image
    logic        seen_blk [n_blocks];
    logic [31:0] lfsr_q [2];  // stream 0 for stimulus and stream 1 for memory timing
    cache_cfg_pkg::block_addr_t last_blk;

    // memory operations accepted during the current request
    cache_bus_pkg::req_type_t   op_type_q [$];
    cache_cfg_pkg::block_addr_t op_addr_q [$];
    cache_cfg_pkg::block_t      op_data_q [$];

    int cycle_cnt     = 0;
    int mem_req_seen  = 0;
    int mem_resp_sent = 0;

    tb_clock_gen u_clock_gen (.clk, .rst_aL);

    cache_top DUT (
        .clk, .rst_aL,
        .req_valid, .req_type, .req_width, .req_addr, .req_wr_data,
        .req_ready, .resp_valid, .resp_data,
        .mem_req_valid, .mem_req_type, .mem_req_block_addr, .mem_req_block_data,
        .mem_req_ready, .mem_resp_valid, .mem_resp_block_data
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int stream, input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q[stream] = lfsr_next(lfsr_q[stream]);
            v = {v[30:0], lfsr_q[stream][0]};
        end
        return v;
    endfunction

    function automatic cache_cfg_pkg::block_t ref_block(input cache_cfg_pkg::block_addr_t blk);
        cache_cfg_pkg::block_t v;
        for (int b = 0; b < 8; b++) begin
            v[b*8 +: 8] = ref_mem[{blk, 3'(b)}];  // byte b sits in lane b
        end
        return v;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic value_error(input string msg);
        abort_run($sformatf("** Error [%0d ns] %s", $time, msg));
    endtask

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit)
            abort_run($sformatf("timeout: test did not finish within %0d cycles", cycle_limit));
    end

    always @(negedge clk) begin
        if (DUT.u_ctrl.u_checks.n_failed != 0)
            abort_run("an assertion bound to the cache controller failed");
    end

    // transfers on the memory request port
    always @(negedge clk) begin
        if (rst_aL === 1'b1 && mem_req_valid === 1'b1 && mem_req_ready === 1'b1)
            mem_req_seen = mem_req_seen + 1;
    end

    task automatic serve_memory();
        cache_bus_pkg::req_type_t   op;
        cache_cfg_pkg::block_addr_t blk;
        repeat (rand_bits(1, 2)) next_cycle();  // 0 to 3 cycles of back-pressure
        mem_req_ready = 1'b1;
        op  = mem_req_type;
        blk = mem_req_block_addr;
        op_type_q.push_back(op);
        op_addr_q.push_back(blk);
        op_data_q.push_back(mem_req_block_data);
        if (op == cache_bus_pkg::WRITE) mem_blocks[blk] = mem_req_block_data;
        next_cycle();
        mem_req_ready = 1'b0;
        repeat (rand_bits(1, 2)) next_cycle();  // answer 1 to 4 cycles later
        mem_resp_valid      = 1'b1;
        mem_resp_block_data = (op == cache_bus_pkg::READ) ? mem_blocks[blk] : '0;
        mem_resp_sent       = mem_resp_sent + 1;
        next_cycle();
        mem_resp_valid = 1'b0;
    endtask

    initial begin
        mem_req_ready       = 1'b0;
        mem_resp_valid      = 1'b0;
        mem_resp_block_data = '0;
        forever begin
            next_cycle();
            if (mem_req_valid === 1'b1) serve_memory();
        end
    end

    task automatic run_request();
        cache_cfg_pkg::block_addr_t blk;
        cache_cfg_pkg::offset_t     off;
        cache_cfg_pkg::block_t      expected, got;
        logic [31:0] r;
        int  n_bytes, accept_cycle, latency, n_ops;
        bit  repeat_blk, fresh;

        r = rand_bits(0, 2);
        repeat_blk = (r[1:0] == 2'd0);  // one in four goes back to the last block
        r = rand_bits(0, 6);
        blk = repeat_blk ? last_blk : (window_base | 13'(r[5:0]));
        fresh = !seen_blk[blk];
        r = rand_bits(0, 1);
        req_type = r[0] ? cache_bus_pkg::WRITE : cache_bus_pkg::READ;
        r = rand_bits(0, 2);
        req_width = (r[1:0] == 2'd0) ? cache_bus_pkg::BYTE :
                    (r[1:0] == 2'd1) ? cache_bus_pkg::HALFWORD : cache_bus_pkg::WORD;
        n_bytes = (req_width == cache_bus_pkg::BYTE) ? 1 :
                  (req_width == cache_bus_pkg::HALFWORD) ? 2 : 4;
        r = rand_bits(0, 3);
        off = r[2:0];
        if (n_bytes > 1) off[0] = 1'b0;  // aligned as the pipeline does it
        if (n_bytes > 2) off[1] = 1'b0;
        req_addr    = {blk, off};
        req_wr_data = rand_bits(0, 32);
        req_valid   = 1'b1;

        if (req_type == cache_bus_pkg::WRITE) begin
            for (int i = 0; i < n_bytes; i++) begin
                ref_mem[{blk, off} + i] = req_wr_data[i*8 +: 8];
            end
        end
        expected = ref_block(blk);

        while (req_ready !== 1'b1) next_cycle();
        accept_cycle = cycle_cnt;  // the cycle in which the request is taken
        next_cycle();
        req_valid = 1'b0;
        while (resp_valid !== 1'b1) next_cycle();
        latency = cycle_cnt - accept_cycle;
        got   = resp_data;
        n_ops = op_type_q.size();

        assert (got === expected) else value_error($sformatf(
            "%s at %h: resp_data %h, expected %h", req_type.name(), req_addr, got, expected));
        if (req_type == cache_bus_pkg::READ) begin
            assert (n_ops == 0 || (n_ops == 1 && op_type_q[0] == cache_bus_pkg::READ &&
                    op_addr_q[0] == blk)) else value_error($sformatf(
                "read at %h: %0d unexpected memory requests", req_addr, n_ops));
            assert (!fresh || n_ops == 1) else value_error($sformatf(
                "read at %h: block never cached but no memory read", req_addr));
            assert (n_ops != 0 || latency == 2) else value_error($sformatf(
                "read hit at %h: response after %0d cycles, expected 2", req_addr, latency));
        end else begin
            assert (n_ops inside {1, 2} && op_type_q[n_ops-1] == cache_bus_pkg::WRITE &&
                    op_addr_q[n_ops-1] == blk && op_data_q[n_ops-1] === expected)
                else value_error($sformatf("write at %h: no matching write-through", req_addr));
            assert (n_ops == 1 || (op_type_q[0] == cache_bus_pkg::READ && op_addr_q[0] == blk))
                else value_error($sformatf("write at %h: bad refill before store", req_addr));
            assert (!fresh || n_ops == 2) else value_error($sformatf(
                "write at %h: block never cached but no refill read", req_addr));
            assert (mem_blocks[blk] === expected) else value_error($sformatf(
                "write at %h: memory holds %h, expected %h", req_addr, mem_blocks[blk], expected));
        end
        if (repeat_blk && !fresh) begin  // same block again so it must hit
            assert ((req_type == cache_bus_pkg::READ) ? (n_ops == 0 && latency == 2) : (n_ops == 1))
                else value_error($sformatf("repeat access at %h did not hit", req_addr));
        end

        op_type_q.delete();
        op_addr_q.delete();
        op_data_q.delete();
        seen_blk[blk] = 1'b1;
        last_blk      = blk;
    endtask

    initial begin
        int low_cycles;
        req_valid   = 1'b0;
        req_type    = cache_bus_pkg::READ;
        req_width   = cache_bus_pkg::BYTE;
        req_addr    = '0;
        req_wr_data = '0;
        last_blk    = window_base;
        lfsr_q[0]   = 32'd89304;
        lfsr_q[1]   = 32'd89304;
        for (int i = 0; i < n_blocks; i++) begin
            mem_blocks[i][63:32] = rand_bits(0, 32);
            mem_blocks[i][31:0]  = rand_bits(0, 32);
            seen_blk[i] = 1'b0;
            for (int b = 0; b < 8; b++) begin
                ref_mem[i*8 + b] = mem_blocks[i][b*8 +: 8];
            end
        end

        @(posedge rst_aL);
        low_cycles = 0;
        while (req_ready !== 1'b1) begin  // invalidation sweep
            assert (mem_req_valid !== 1'b1)
                else abort_run("memory request issued before any pipeline request");
            low_cycles++;
            next_cycle();
        end
        assert (low_cycles >= 16) else value_error($sformatf(
            "req_ready rose %0d cycles after reset, expected at least 16", low_cycles));

        for (int n = 0; n < n_requests; n++) begin
            run_request();
        end
        assert (mem_req_seen == mem_resp_sent) else value_error($sformatf(
            "%0d memory requests seen, %0d responses sent", mem_req_seen, mem_resp_sent));
        if (DUT.u_ctrl.u_checks.n_failed != 0) begin
            abort_run("an assertion bound to the cache controller failed");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

// File: dv/cache_assertions.sv
module cache_assertions (
    input logic                       clk,
    input logic                       rst_aL,
    input cache_bus_pkg::ctrl_state_t state,
    input logic                       req_ready,
    input logic                       resp_valid,
    input logic                       mem_req_valid,
    input cache_bus_pkg::req_type_t   mem_req_type,
    input cache_cfg_pkg::block_addr_t mem_req_block_addr,
    input logic                       mem_req_ready,
    input logic                       mem_resp_valid,
    input logic                       hit,
    input logic                       hit_way,
    input logic                       fill_en,
    input logic                       fill_way,
    input cache_cfg_pkg::index_t      fill_index,
    input cache_cfg_pkg::tag_t        fill_tag
);
    timeunit 1ns;
    timeprecision 1ps;

    int n_failed = 0;  // failed assertions so far

    logic                  mem_busy;  // accepted and response still due
    logic                  last_fill_q;
    logic                  last_way_q;
    cache_cfg_pkg::index_t last_index_q;
    cache_cfg_pkg::tag_t   last_tag_q;

    always_ff @(posedge clk) begin
        if (!rst_aL) begin
            mem_busy <= 1'b0;
        end else if (mem_req_valid && mem_req_ready) begin
            mem_busy <= 1'b1;
        end else if (mem_resp_valid) begin
            mem_busy <= 1'b0;
        end
    end

    // the most recently filled block is always still cached
    always_ff @(posedge clk) begin
        if (!rst_aL) begin
            last_fill_q  <= 1'b0;
            last_way_q   <= 1'b0;
            last_index_q <= '0;
            last_tag_q   <= '0;
        end else if (fill_en) begin
            last_fill_q  <= 1'b1;
            last_way_q   <= fill_way;
            last_index_q <= fill_index;
            last_tag_q   <= fill_tag;
        end
    end

    // request fields hold until the memory controller takes them
    mem_req_stable: assert property (@(posedge clk) disable iff (!rst_aL)
        mem_req_valid && !mem_req_ready |=>
            mem_req_valid && $stable(mem_req_type) && $stable(mem_req_block_addr))
        else begin
            $error("memory request dropped or changed while waiting for mem_req_ready");
            n_failed++;
        end

    resp_one_cycle: assert property (@(posedge clk) disable iff (!rst_aL)
        resp_valid |=> !resp_valid)
        else begin
            $error("resp_valid held for more than one cycle");
            n_failed++;
        end

    // no new pipeline request while memory is busy
    busy_not_ready: assert property (@(posedge clk) disable iff (!rst_aL)
        (mem_req_valid || mem_busy) |-> !req_ready)
        else begin
            $error("req_ready high with a memory request outstanding");
            n_failed++;
        end

    // fill fields carry the latched request during LOOKUP
    hit_in_fill_way: assert property (@(posedge clk) disable iff (!rst_aL)
        (state == cache_bus_pkg::LOOKUP && last_fill_q &&
         fill_index == last_index_q && fill_tag == last_tag_q)
            |-> hit && hit_way == last_way_q)
        else begin
            $error("lookup of the last filled block missed or reported the wrong way");
            n_failed++;
        end

endmodule

bind cache_ctrl cache_assertions u_checks (
    .clk, .rst_aL, .state,
    .req_ready, .resp_valid,
    .mem_req_valid, .mem_req_type, .mem_req_block_addr, .mem_req_ready,
    .mem_resp_valid,
    .hit, .hit_way,
    .fill_en, .fill_way, .fill_index, .fill_tag
);

// File: dv/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk,
    output logic rst_aL
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int half_period  = 50;  // 100 ns clock
    localparam int reset_cycles = 5;

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    initial begin
        rst_aL = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #10 rst_aL = 1'b1;  // released with the other stimulus, after the edge
    end

endmodule

// File: hw/cache_top.sv
module cache_top (
    input  logic                       clk,
    input  logic                       rst_aL,
    // pipeline request and response
    input  logic                       req_valid,
    input  cache_bus_pkg::req_type_t   req_type,
    input  cache_bus_pkg::req_width_t  req_width,
    input  cache_cfg_pkg::addr_t       req_addr,
    input  cache_cfg_pkg::word_t       req_wr_data,
    output logic                       req_ready,
    output logic                       resp_valid,
    output cache_cfg_pkg::block_t      resp_data,
    // memory controller request and response
    output logic                       mem_req_valid,
    output cache_bus_pkg::req_type_t   mem_req_type,
    output cache_cfg_pkg::block_addr_t mem_req_block_addr,
    output cache_cfg_pkg::block_t      mem_req_block_data,
    input  logic                       mem_req_ready,
    input  logic                       mem_resp_valid,
    input  cache_cfg_pkg::block_t      mem_resp_block_data
);

    logic                      hit, hit_way, victim_bit, lfsr_step;
    logic [1:0]                set_valid;
    logic                      rd_en, clr_en, fill_en, fill_way;
    logic                      refill_en, store_en, wr_way;
    cache_cfg_pkg::index_t     rd_index, clr_index, fill_index, wr_index;
    cache_cfg_pkg::tag_t       cmp_tag, fill_tag;
    cache_bus_pkg::req_width_t st_width;
    cache_cfg_pkg::offset_t    st_offset;
    cache_cfg_pkg::word_t      st_data;
    cache_cfg_pkg::block_t     rd_block;

    cache_ctrl u_ctrl (
        .clk, .rst_aL,
        .req_valid, .req_type, .req_width, .req_addr, .req_wr_data,
        .req_ready, .resp_valid,
        .mem_req_valid, .mem_req_type, .mem_req_block_addr,
        .mem_req_ready, .mem_resp_valid,
        .hit, .hit_way, .set_valid, .victim_bit,
        .rd_en, .rd_index, .cmp_tag,
        .clr_en, .clr_index,
        .fill_en, .fill_way, .fill_index, .fill_tag,
        .refill_en, .store_en, .wr_way, .wr_index,
        .st_width, .st_offset, .st_data,
        .lfsr_step
    );

    tag_store u_tags (
        .clk, .rst_aL,
        .rd_en, .rd_index, .cmp_tag,
        .clr_en, .clr_index,
        .fill_en, .fill_way, .fill_index, .fill_tag,
        .hit, .hit_way, .set_valid
    );

    data_store u_data (
        .clk, .rst_aL,
        .rd_en, .rd_index,
        .rd_way      (wr_way),  // controller's latched way
        .refill_en,
        .refill_data (mem_resp_block_data),
        .store_en, .wr_way, .wr_index,
        .st_width, .st_offset, .st_data,
        .rd_block
    );

    way_lfsr u_lfsr (
        .clk, .rst_aL,
        .step       (lfsr_step),
        .victim_bit
    );

    // one block register feeds both the response and the write-through
    assign resp_data          = rd_block;
    assign mem_req_block_data = rd_block;

endmodule

// File: hw/cache_ctrl.sv
module cache_ctrl (
    input  logic                       clk,
    input  logic                       rst_aL,
    // pipeline side
    input  logic                       req_valid,
    input  cache_bus_pkg::req_type_t   req_type,
    input  cache_bus_pkg::req_width_t  req_width,
    input  cache_cfg_pkg::addr_t       req_addr,
    input  cache_cfg_pkg::word_t       req_wr_data,
    output logic                       req_ready,
    output logic                       resp_valid,
    // memory side
    output logic                       mem_req_valid,
    output cache_bus_pkg::req_type_t   mem_req_type,
    output cache_cfg_pkg::block_addr_t mem_req_block_addr,
    input  logic                       mem_req_ready,
    input  logic                       mem_resp_valid,
    // from the stores and the lfsr
    input  logic                       hit,
    input  logic                       hit_way,
    input  logic [1:0]                 set_valid,
    input  logic                       victim_bit,
    // to the stores and the lfsr
    output logic                       rd_en,
    output cache_cfg_pkg::index_t      rd_index,
    output cache_cfg_pkg::tag_t        cmp_tag,
    output logic                       clr_en,
    output cache_cfg_pkg::index_t      clr_index,
    output logic                       fill_en,
    output logic                       fill_way,
    output cache_cfg_pkg::index_t      fill_index,
    output cache_cfg_pkg::tag_t        fill_tag,
    output logic                       refill_en,
    output logic                       store_en,
    output logic                       wr_way,
    output cache_cfg_pkg::index_t      wr_index,
    output cache_bus_pkg::req_width_t  st_width,
    output cache_cfg_pkg::offset_t     st_offset,
    output cache_cfg_pkg::word_t       st_data,
    output logic                       lfsr_step
);

    cache_bus_pkg::ctrl_state_t state, state_d;
    cache_cfg_pkg::index_t      sweep_cnt;
    logic                       way_q;     // way being hit, filled or stored
    cache_bus_pkg::req_type_t   mem_op_q;  // refill read or write-through

    // accepted request
    cache_bus_pkg::req_type_t   req_type_q;
    cache_bus_pkg::req_width_t  req_width_q;
    cache_cfg_pkg::tag_t        tag_q;
    cache_cfg_pkg::index_t      index_q;
    cache_cfg_pkg::offset_t     offset_q;
    cache_cfg_pkg::word_t       wr_data_q;

    logic new_way;

    // first invalid way, else the random pick
    assign new_way = !set_valid[0] ? 1'b0 :
                     !set_valid[1] ? 1'b1 : victim_bit;

    always_comb begin
        state_d = state;
        case (state)
            cache_bus_pkg::INIT: begin
                if (sweep_cnt == cache_cfg_pkg::index_t'(cache_cfg_pkg::n_sets - 1))
                    state_d = cache_bus_pkg::IDLE;
            end
            cache_bus_pkg::IDLE:
                if (req_valid) state_d = cache_bus_pkg::LOOKUP;
            cache_bus_pkg::LOOKUP: begin
                if (!hit) state_d = cache_bus_pkg::MEM_REQ;  // refill first, also for stores
                else if (req_type_q == cache_bus_pkg::WRITE) state_d = cache_bus_pkg::STORE;
                else state_d = cache_bus_pkg::RESPOND;
            end
            cache_bus_pkg::MEM_REQ:
                if (mem_req_ready) state_d = cache_bus_pkg::MEM_WAIT;
            cache_bus_pkg::MEM_WAIT: begin
                if (mem_resp_valid)
                    state_d = (mem_op_q == cache_bus_pkg::READ) ? cache_bus_pkg::REFILL
                                                                : cache_bus_pkg::RESPOND;
            end
            cache_bus_pkg::REFILL:
                state_d = (req_type_q == cache_bus_pkg::WRITE) ? cache_bus_pkg::STORE
                                                               : cache_bus_pkg::RESPOND;
            cache_bus_pkg::STORE:   state_d = cache_bus_pkg::MEM_REQ;  // write-through
            cache_bus_pkg::RESPOND: state_d = cache_bus_pkg::IDLE;
            default:                state_d = cache_bus_pkg::INIT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_aL) begin
            state     <= cache_bus_pkg::INIT;
            sweep_cnt <= '0;
            way_q     <= 1'b0;
            mem_op_q  <= cache_bus_pkg::READ;
        end else begin
            state <= state_d;
            if (state == cache_bus_pkg::INIT) sweep_cnt <= sweep_cnt + 1'b1;
            if (state == cache_bus_pkg::LOOKUP) begin
                way_q    <= hit ? hit_way : new_way;
                mem_op_q <= cache_bus_pkg::READ;
            end
            if (state == cache_bus_pkg::STORE) mem_op_q <= cache_bus_pkg::WRITE;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            req_type_q  <= req_type;
            req_width_q <= req_width;
            {tag_q, index_q, offset_q} <= req_addr;
            wr_data_q   <= req_wr_data;
        end
    end

    assign req_ready  = (state == cache_bus_pkg::IDLE);
    assign resp_valid = (state == cache_bus_pkg::RESPOND);

    // request fields come from registers only, so they hold under back-pressure
    assign mem_req_valid      = (state == cache_bus_pkg::MEM_REQ);
    assign mem_req_type       = mem_op_q;
    assign mem_req_block_addr = {tag_q, index_q};

    assign rd_en    = req_valid & req_ready;  // arrays read in the accept cycle
    assign rd_index = req_addr[cache_cfg_pkg::offset_w +: cache_cfg_pkg::index_w];
    assign cmp_tag  = tag_q;

    assign clr_en    = (state == cache_bus_pkg::INIT);
    assign clr_index = sweep_cnt;

    // block data lands with the response, the tag follows in REFILL
    assign refill_en  = (state == cache_bus_pkg::MEM_WAIT) & mem_resp_valid &
                        (mem_op_q == cache_bus_pkg::READ);
    assign fill_en    = (state == cache_bus_pkg::REFILL);
    assign fill_way   = way_q;
    assign fill_index = index_q;
    assign fill_tag   = tag_q;
    assign lfsr_step  = (state == cache_bus_pkg::REFILL);

    assign store_en  = (state == cache_bus_pkg::STORE);
    assign wr_way    = way_q;
    assign wr_index  = index_q;
    assign st_width  = req_width_q;
    assign st_offset = offset_q;
    assign st_data   = wr_data_q;

endmodule

// File: hw/data_store.sv
module data_store (
    input  logic                      clk,
    input  logic                      rst_aL,
    input  logic                      rd_en,
    input  cache_cfg_pkg::index_t     rd_index,
    input  logic                      rd_way,
    input  logic                      refill_en,
    input  cache_cfg_pkg::block_t     refill_data,
    input  logic                      store_en,
    input  logic                      wr_way,
    input  cache_cfg_pkg::index_t     wr_index,
    input  cache_bus_pkg::req_width_t st_width,
    input  cache_cfg_pkg::offset_t    st_offset,
    input  cache_cfg_pkg::word_t      st_data,
    output cache_cfg_pkg::block_t     rd_block
);

    cache_cfg_pkg::block_t way_data [cache_cfg_pkg::n_ways][cache_cfg_pkg::n_sets];
    cache_cfg_pkg::block_t rd_q     [cache_cfg_pkg::n_ways];

    cache_cfg_pkg::byte_mask_t st_mask;
    cache_cfg_pkg::block_t     st_lanes;
    cache_cfg_pkg::block_t     st_bits;   // st_mask widened to bits
    cache_cfg_pkg::block_t     merged;

    // the pipeline aligns stores, so a shift of the base mask is enough
    always_comb begin
        case (st_width)
            cache_bus_pkg::BYTE: begin
                st_mask  = 8'b0000_0001 << st_offset;
                st_lanes = {8{st_data[7:0]}};
            end
            cache_bus_pkg::HALFWORD: begin
                st_mask  = 8'b0000_0011 << st_offset;
                st_lanes = {4{st_data[15:0]}};
            end
            cache_bus_pkg::WORD: begin
                st_mask  = 8'b0000_1111 << st_offset;
                st_lanes = {2{st_data}};
            end
            default: begin
                st_mask  = '0;
                st_lanes = '0;
            end
        endcase
        for (int b = 0; b < cache_cfg_pkg::block_bytes; b++) begin
            st_bits[b*8 +: 8] = {8{st_mask[b]}};
        end
    end

    // merge into the line currently held in the read register
    assign merged = (rd_q[wr_way] & ~st_bits) | (st_lanes & st_bits);

    always_ff @(posedge clk) begin
        if (refill_en) begin
            way_data[wr_way][wr_index] <= refill_data;
        end else if (store_en) begin
            way_data[wr_way][wr_index] <= merged;
        end
    end

    // writes pass through so response and write-through see the new line
    always_ff @(posedge clk) begin
        if (!rst_aL) begin
            rd_q[0] <= '0;
            rd_q[1] <= '0;
        end else if (refill_en) begin
            rd_q[wr_way] <= refill_data;
        end else if (store_en) begin
            rd_q[wr_way] <= merged;
        end else if (rd_en) begin
            rd_q[0] <= way_data[0][rd_index];
            rd_q[1] <= way_data[1][rd_index];
        end
    end

    assign rd_block = rd_q[rd_way];

endmodule

// File: hw/tag_store.sv
module tag_store (
    input  logic                  clk,
    input  logic                  rst_aL,
    input  logic                  rd_en,
    input  cache_cfg_pkg::index_t rd_index,
    input  cache_cfg_pkg::tag_t   cmp_tag,
    input  logic                  clr_en,
    input  cache_cfg_pkg::index_t clr_index,
    input  logic                  fill_en,
    input  logic                  fill_way,
    input  cache_cfg_pkg::index_t fill_index,
    input  cache_cfg_pkg::tag_t   fill_tag,
    output logic                  hit,
    output logic                  hit_way,
    output logic [1:0]            set_valid
);

    cache_cfg_pkg::tag_t tag_arr   [cache_cfg_pkg::n_ways][cache_cfg_pkg::n_sets];
    logic                valid_arr [cache_cfg_pkg::n_ways][cache_cfg_pkg::n_sets];

    cache_cfg_pkg::tag_t rd_tag_q   [cache_cfg_pkg::n_ways];
    logic [1:0]          rd_valid_q;  // bit w belongs to way w
    logic [1:0]          way_match;

    // array writes, sweep and fill never overlap
    always_ff @(posedge clk) begin
        if (clr_en) begin
            valid_arr[0][clr_index] <= 1'b0;
            valid_arr[1][clr_index] <= 1'b0;
        end else if (fill_en) begin
            valid_arr[fill_way][fill_index] <= 1'b1;
            tag_arr[fill_way][fill_index]   <= fill_tag;
        end
    end

    // registered read of the addressed set
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_tag_q[0] <= tag_arr[0][rd_index];
            rd_tag_q[1] <= tag_arr[1][rd_index];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_aL) begin
            rd_valid_q <= 2'b00;
        end else if (rd_en) begin
            rd_valid_q <= {valid_arr[1][rd_index], valid_arr[0][rd_index]};
        end
    end

    // compare against the tag latched by the controller
    always_comb begin
        for (int w = 0; w < cache_cfg_pkg::n_ways; w++) begin
            way_match[w] = rd_valid_q[w] & (rd_tag_q[w] == cmp_tag);
        end
    end

    assign hit       = |way_match;
    assign hit_way   = way_match[1];  // a tag lives in one way only
    assign set_valid = rd_valid_q;

endmodule

// File: hw/way_lfsr.sv
module way_lfsr (
    input  logic clk,
    input  logic rst_aL,
    input  logic step,
    output logic victim_bit
);

    logic [7:0] lfsr_q;
    logic       feedback;

    // x^8 + x^6 + x^5 + x^4 + 1, maximal length
    assign feedback = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

    always_ff @(posedge clk) begin
        if (!rst_aL) begin
            lfsr_q <= 8'hA5;  // any nonzero seed
        end else if (step) begin
            lfsr_q <= {lfsr_q[6:0], feedback};
        end
    end

    assign victim_bit = lfsr_q[7];

endmodule

// File: hw/cache_bus_pkg.sv
package cache_bus_pkg;

    // request kind on both the pipeline and memory ports
    typedef enum logic {
        READ  = 1'b0,
        WRITE = 1'b1
    } req_type_t;

    // store width, only meaningful for writes
    typedef enum logic [1:0] {
        BYTE     = 2'd0,
        HALFWORD = 2'd1,
        WORD     = 2'd2
    } req_width_t;

    // controller sequencing
    typedef enum logic [2:0] {
        INIT,      // valid bit sweep after reset
        IDLE,
        LOOKUP,
        MEM_REQ,
        MEM_WAIT,
        REFILL,
        STORE,
        RESPOND
    } ctrl_state_t;

endpackage

// File: hw/cache_cfg_pkg.sv
package cache_cfg_pkg;

    // fixed geometry of the data cache
    localparam int addr_w   = 16;
    localparam int offset_w = 3;   // 8-byte blocks
    localparam int index_w  = 4;
    localparam int tag_w    = addr_w - index_w - offset_w;
    localparam int n_sets   = 16;
    localparam int n_ways   = 2;
    localparam int block_w  = 64;
    localparam int word_w   = 32;

    localparam int block_bytes = block_w / 8;

    // byte address as seen by the pipeline
    typedef logic [addr_w-1:0] addr_t;

    // tag and index, the memory controller works on whole blocks
    typedef logic [tag_w+index_w-1:0] block_addr_t;

    typedef logic [tag_w-1:0]    tag_t;
    typedef logic [index_w-1:0]  index_t;
    typedef logic [offset_w-1:0] offset_t;

    typedef logic [word_w-1:0]  word_t;   // store data
    typedef logic [block_w-1:0] block_t;  // line data

    // one bit per byte lane of a block
    typedef logic [block_bytes-1:0] byte_mask_t;

endpackage
